/* common/switch_pkg.sv */
`default_nettype none

package switch_pkg;

    // port count, default for the top level
    localparam int NUM_PORTS = 4;

    // word width on every input and output port
    localparam int DATA_W = 16;

    // header layout
    // destination sits in the low bits, length field starts at bit 7
    localparam int DEST_W   = 2;
    localparam int DEST_LSB = 0;
    localparam int LEN_LSB  = 7;

    // largest packet in words, header included
    localparam int PKT_MAX_WORDS = 17;

    // output queue sizing
    localparam int QUEUE_DEPTH = 64;

    // fill counter must hold QUEUE_DEPTH itself
    localparam int FILL_W = 7;

endpackage

`default_nettype wire

/* egress_drain/egress_drain.sv */
`timescale 1ns/10ps
`default_nettype none

module egress_drain #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [NUM_PORTS-1:0]                         ready,
    input  logic [NUM_PORTS-1:0]                         pkt_avail,
    input  logic [NUM_PORTS-1:0]                         head_eop,
    input  logic [NUM_PORTS-1:0][switch_pkg::DATA_W-1:0] head_data,
    output logic [NUM_PORTS-1:0]                         rd_en,
    output logic [NUM_PORTS-1:0]                         rd_s,
    output logic [NUM_PORTS-1:0]                         rd_sop,
    output logic [NUM_PORTS-1:0]                         rd_eop,
    output logic [NUM_PORTS-1:0]                         rd_vld,
    output logic [NUM_PORTS-1:0][switch_pkg::DATA_W-1:0] rd_data
);
    import switch_pkg::*;

    // state names what the output registers show this cycle
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_FIRST,
        ST_BODY
    } drain_state_t;

    for (genvar j = 0; j < NUM_PORTS; j++) begin : g_port
        drain_state_t      state_q;
        logic [DATA_W-1:0] word_q;
        logic              last_q;
        logic              showing;
        logic              take;

        assign showing = (state_q == ST_FIRST) || (state_q == ST_BODY);

        // header is read during start, then one word per cycle
        // until the word on the output carries eop
        assign take = (state_q == ST_START) || (showing && !last_q);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                state_q <= ST_IDLE;
            end else begin
                case (state_q)
                    ST_IDLE: begin
                        // pulses on a busy or empty port are dropped
                        if (ready[j] && pkt_avail[j]) begin
                            state_q <= ST_START;
                        end
                    end
                    ST_START: begin
                        state_q <= ST_FIRST;
                    end
                    ST_FIRST, ST_BODY: begin
                        state_q <= last_q ? ST_IDLE : ST_BODY;
                    end
                    default: begin
                        state_q <= ST_IDLE;
                    end
                endcase
            end
        end

        // output word and its eop flag
        always_ff @(posedge clk) begin
            if (take) begin
                word_q <= head_data[j];
                last_q <= head_eop[j];
            end
        end

        assign rd_en[j]   = take;
        assign rd_s[j]    = (state_q == ST_START);
        assign rd_sop[j]  = (state_q == ST_FIRST);
        assign rd_vld[j]  = showing;
        assign rd_eop[j]  = showing && last_q;
        assign rd_data[j] = word_q;
    end

endmodule

`default_nettype wire

/* port_queue/port_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module port_queue #(
    parameter int QUEUE_DEPTH = switch_pkg::QUEUE_DEPTH,
    parameter int FILL_W      = switch_pkg::FILL_W
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr,
    input  logic [switch_pkg::DATA_W-1:0] wr_data,
    input  logic                          wr_eop,
    input  logic                          rd_en,
    output logic [switch_pkg::DATA_W-1:0] head_data,
    output logic                          head_eop,
    output logic                          pkt_avail,
    output logic                          almost_full,
    output logic                          full
);
    import switch_pkg::*;

    localparam int ADDR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    // room for a maximum packet plus the word held in the ingress register
    localparam int AFULL_LVL = QUEUE_DEPTH - (PKT_MAX_WORDS + 2);

    // each entry is {eop, data}
    logic [DATA_W:0]     mem [QUEUE_DEPTH];
    logic [DATA_W:0]     head_word;

    logic [ADDR_W-1:0]   wr_ptr_q;
    logic [ADDR_W-1:0]   rd_ptr_q;
    logic [FILL_W-1:0]   fill_q;
    logic [FILL_W-1:0]   pkt_cnt_q;

    logic                wr_pkt;
    logic                rd_pkt;

    function automatic logic [ADDR_W-1:0] ptr_next(input logic [ADDR_W-1:0] ptr);
        if (ptr == ADDR_W'(QUEUE_DEPTH - 1)) begin
            ptr_next = '0;
        end else begin
            ptr_next = ptr + 1'b1;
        end
    endfunction

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr_q] <= {wr_eop, wr_data};
        end
    end

    // show-ahead read
    assign head_word = mem[rd_ptr_q];
    assign head_eop  = head_word[DATA_W];
    assign head_data = head_word[DATA_W-1:0];

    assign wr_pkt = wr && wr_eop;
    assign rd_pkt = rd_en && head_eop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (wr) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (rd_en) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
        end
    end

    // word count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_q <= '0;
        end else begin
            case ({wr, rd_en})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase
        end
    end

    // complete packets held, counted on eop in and eop out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_cnt_q <= '0;
        end else begin
            case ({wr_pkt, rd_pkt})
                2'b10:   pkt_cnt_q <= pkt_cnt_q + 1'b1;
                2'b01:   pkt_cnt_q <= pkt_cnt_q - 1'b1;
                default: pkt_cnt_q <= pkt_cnt_q;
            endcase
        end
    end

    assign pkt_avail   = (pkt_cnt_q != '0);
    assign almost_full = (fill_q > FILL_W'(AFULL_LVL));
    assign full        = (fill_q == FILL_W'(QUEUE_DEPTH));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile and run the packet switch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_packet_switch -Mdir obj_dir -o sim_packet_switch
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_packet_switch)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

/* src/ingress_select.sv */
`timescale 1ns/10ps
`default_nettype none

module ingress_select #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [NUM_PORTS-1:0]                         wr_sop,
    input  logic [NUM_PORTS-1:0]                         wr_eop,
    input  logic [NUM_PORTS-1:0]                         wr_vld,
    input  logic [NUM_PORTS-1:0][switch_pkg::DATA_W-1:0] wr_data,
    input  logic [NUM_PORTS-1:0]                         q_afull,
    output logic [NUM_PORTS-1:0]                         pause,
    output logic [NUM_PORTS-1:0]                         q_wr,
    output logic [switch_pkg::DATA_W-1:0]                q_data,
    output logic                                         q_eop
);
    import switch_pkg::*;

    localparam int TOK_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    // control state
    logic              active_q;
    logic [TOK_W-1:0]  token_q;
    logic              granted_q;
    logic [DEST_W-1:0] dest_q;

    // decode of the token port
    logic                 any_afull;
    logic [TOK_W-1:0]     token_nxt;
    logic [DEST_W-1:0]    hdr_dest;
    logic                 tok_sop;
    logic                 tok_eop;
    logic                 tok_vld;
    logic [NUM_PORTS-1:0] tok_onehot;
    logic                 grant_start;
    logic                 grant_end;

    function automatic logic [NUM_PORTS-1:0] port_bit(input int unsigned idx);
        port_bit = NUM_PORTS'(1) << idx;
    endfunction

    assign any_afull  = |q_afull;
    assign tok_sop    = wr_sop[token_q];
    assign tok_eop    = wr_eop[token_q];
    assign tok_vld    = wr_vld[token_q];
    assign hdr_dest   = wr_data[token_q][DEST_LSB +: DEST_W];
    assign tok_onehot = port_bit(token_q);

    // wrap explicitly so a non power of two port count still works
    assign token_nxt = (token_q == TOK_W'(NUM_PORTS - 1)) ? '0 : token_q + 1'b1;

    // new packets only while every queue has room for a whole one
    assign grant_start = active_q && !granted_q && !any_afull && tok_sop && tok_vld;
    assign grant_end   = granted_q && tok_vld && tok_eop;

    // only the token port may send
    // back-pressure closes it unless its packet is already running
    always_comb begin
        pause = '1;
        if (active_q && (granted_q || !any_afull)) begin
            pause = ~tok_onehot;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q  <= 1'b0;
            token_q   <= '0;
            granted_q <= 1'b0;
            dest_q    <= '0;
        end else begin
            active_q <= 1'b1;
            if (grant_start) begin
                granted_q <= 1'b1;
                dest_q    <= hdr_dest;
            end else if (grant_end) begin
                granted_q <= 1'b0;
                token_q   <= token_nxt;
            end else if (active_q && !granted_q) begin
                // no sop taken, move on to the next port
                token_q <= token_nxt;
            end
        end
    end

    // header goes straight to the queue named in it,
    // later words follow the latched destination
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_wr <= '0;
        end else if (grant_start) begin
            q_wr <= port_bit(hdr_dest);
        end else if (granted_q && tok_vld) begin
            q_wr <= port_bit(dest_q);
        end else begin
            q_wr <= '0;
        end
    end

    // shared write bus, qualified by q_wr
    always_ff @(posedge clk) begin
        q_data <= wr_data[token_q];
        q_eop  <= tok_eop;
    end

endmodule

`default_nettype wire

/* src/packet_switch.sv */
`timescale 1ns/10ps
`default_nettype none

module packet_switch #(
    parameter int NUM_PORTS   = switch_pkg::NUM_PORTS,
    parameter int QUEUE_DEPTH = switch_pkg::QUEUE_DEPTH
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [NUM_PORTS-1:0]                         wr_sop,
    input  logic [NUM_PORTS-1:0]                         wr_eop,
    input  logic [NUM_PORTS-1:0]                         wr_vld,
    input  logic [NUM_PORTS-1:0][switch_pkg::DATA_W-1:0] wr_data,
    input  logic [NUM_PORTS-1:0]                         ready,
    output logic [NUM_PORTS-1:0]                         pause,
    output logic                                         full,
    output logic                                         almost_full,
    output logic [NUM_PORTS-1:0]                         rd_s,
    output logic [NUM_PORTS-1:0]                         rd_sop,
    output logic [NUM_PORTS-1:0]                         rd_eop,
    output logic [NUM_PORTS-1:0]                         rd_vld,
    output logic [NUM_PORTS-1:0][switch_pkg::DATA_W-1:0] rd_data
);
    import switch_pkg::*;

    // shared write bus from ingress
    logic [NUM_PORTS-1:0]              q_wr;
    logic [DATA_W-1:0]                 q_data;
    logic                              q_eop;

    // per-queue status and drain signals
    logic [NUM_PORTS-1:0]              q_afull;
    logic [NUM_PORTS-1:0]              q_full;
    logic [NUM_PORTS-1:0]              pkt_avail;
    logic [NUM_PORTS-1:0]              head_eop;
    logic [NUM_PORTS-1:0][DATA_W-1:0]  head_data;
    logic [NUM_PORTS-1:0]              rd_en;

    ingress_select #(
        .NUM_PORTS (NUM_PORTS)
    ) u_ingress (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .q_afull (q_afull),
        .pause   (pause),
        .q_wr    (q_wr),
        .q_data  (q_data),
        .q_eop   (q_eop)
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_queue
        port_queue #(
            .QUEUE_DEPTH (QUEUE_DEPTH),
            .FILL_W      (FILL_W)
        ) u_queue (
            .clk         (clk),
            .rst_n       (rst_n),
            .wr          (q_wr[p]),
            .wr_data     (q_data),
            .wr_eop      (q_eop),
            .rd_en       (rd_en[p]),
            .head_data   (head_data[p]),
            .head_eop    (head_eop[p]),
            .pkt_avail   (pkt_avail[p]),
            .almost_full (q_afull[p]),
            .full        (q_full[p])
        );
    end

    egress_drain #(
        .NUM_PORTS (NUM_PORTS)
    ) u_egress (
        .clk       (clk),
        .rst_n     (rst_n),
        .ready     (ready),
        .pkt_avail (pkt_avail),
        .head_eop  (head_eop),
        .head_data (head_data),
        .rd_en     (rd_en),
        .rd_s      (rd_s),
        .rd_sop    (rd_sop),
        .rd_eop    (rd_eop),
        .rd_vld    (rd_vld),
        .rd_data   (rd_data)
    );

    // switch level status, any queue counts
    assign full        = |q_full;
    assign almost_full = |q_afull;

endmodule

`default_nettype wire

/* tb.f */
common/switch_pkg.sv
src/ingress_select.sv
port_queue/port_queue.sv
egress_drain/egress_drain.sv
src/packet_switch.sv
testbench/tb_packet_switch.sv

/* testbench/tb_packet_switch.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_packet_switch;
    import switch_pkg::*;

    // length field runs from LEN_LSB to the top of the header word
    localparam int LEN_W = DATA_W - LEN_LSB;

    logic                             clk;
    logic                             rst_n;
    logic [NUM_PORTS-1:0]             wr_sop;
    logic [NUM_PORTS-1:0]             wr_eop;
    logic [NUM_PORTS-1:0]             wr_vld;
    logic [NUM_PORTS-1:0][DATA_W-1:0] wr_data;
    logic [NUM_PORTS-1:0]             ready;
    logic [NUM_PORTS-1:0]             pause;
    logic                             full;
    logic                             almost_full;
    logic [NUM_PORTS-1:0]             rd_s;
    logic [NUM_PORTS-1:0]             rd_sop;
    logic [NUM_PORTS-1:0]             rd_eop;
    logic [NUM_PORTS-1:0]             rd_vld;
    logic [NUM_PORTS-1:0][DATA_W-1:0] rd_data;

    // reference model, each entry is {sop, eop, data}
    logic [DATA_W+1:0]    exp_q [NUM_PORTS][$];
    // edge at which each complete packet's eop was accepted
    int                   done_q [NUM_PORTS][$];
    logic [NUM_PORTS-1:0] in_pkt = '0;
    logic [NUM_PORTS-1:0] exp_s = '0;
    logic [NUM_PORTS-1:0] s_prev = '0;
    logic [NUM_PORTS-1:0] body = '0;
    logic [DEST_W-1:0]    cur_dest [NUM_PORTS];
    int                   cyc = 0;
    int                   af_cycles = 0;
    int                   err_cnt = 0;
    logic [NUM_PORTS-1:0] ready_en;
    logic [31:0]          rnd;

    packet_switch #(
        .NUM_PORTS   (NUM_PORTS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .ready       (ready),
        .pause       (pause),
        .full        (full),
        .almost_full (almost_full),
        .rd_s        (rd_s),
        .rd_sop      (rd_sop),
        .rd_eop      (rd_eop),
        .rd_vld      (rd_vld),
        .rd_data     (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] s;
        s = rnd;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rnd = s;
        return s;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Fail %s got %h exp %h", name, got, exp);
        err_cnt++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error: %s", msg);
        err_cnt++;
    endtask

    task automatic abort_run(input string msg);
        $display("Timeout: %s", msg);
        $display("Checks failed");
        $finish;
    endtask

    task automatic end_test(input string name, input int start_err);
        int n;
        n = err_cnt - start_err;
        $display("test %s: %s (%0d errors)", name, (n == 0) ? "ok" : "failed", n);
    endtask

    task automatic check_idle_outputs();
        assert (pause == '1) else report_mismatch("pause", 32'(pause), 32'({NUM_PORTS{1'b1}}));
        assert (!full) else report_mismatch("full", 32'(full), 32'd0);
        assert (!almost_full) else report_mismatch("almost_full", 32'(almost_full), 32'd0);
        assert (rd_s == '0) else report_mismatch("rd_s", 32'(rd_s), 32'd0);
        assert (rd_sop == '0) else report_mismatch("rd_sop", 32'(rd_sop), 32'd0);
        assert (rd_eop == '0) else report_mismatch("rd_eop", 32'(rd_eop), 32'd0);
        assert (rd_vld == '0) else report_mismatch("rd_vld", 32'(rd_vld), 32'd0);
    endtask

    // header held on the port until the token reaches it
    task automatic send_packet(input int src, input int dst, input int ndata);
        int waited;
        logic [DATA_W-1:0] hdr;
        hdr = DATA_W'(next_rand());
        hdr[DATA_W-1:LEN_LSB] = LEN_W'(ndata + 1);
        hdr[DEST_LSB +: DEST_W] = DEST_W'(dst);
        wr_sop[src]  <= 1'b1;
        wr_vld[src]  <= 1'b1;
        wr_eop[src]  <= 1'b0;
        wr_data[src] <= hdr;
        waited = 0;
        @(posedge clk);
        while (pause[src]) begin
            waited++;
            if (waited > 300) begin
                abort_run("input port never got a grant");
            end
            @(posedge clk);
        end
        for (int k = 1; k <= ndata; k++) begin
            wr_sop[src]  <= 1'b0;
            wr_eop[src]  <= (k == ndata);
            wr_data[src] <= DATA_W'(next_rand());
            @(posedge clk);
        end
        wr_sop[src] <= 1'b0;
        wr_vld[src] <= 1'b0;
        wr_eop[src] <= 1'b0;
    endtask

    function automatic bit queues_empty();
        foreach (exp_q[i]) begin
            if (exp_q[i].size() != 0) begin
                return 1'b0;
            end
        end
        return (in_pkt == '0);
    endfunction

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (!queues_empty()) begin
            n++;
            if (n > limit) begin
                abort_run("output queues did not drain");
            end
            @(posedge clk);
        end
    endtask

    // one pulse per cycle, rotating over the enabled ports
    initial begin : ready_driver
        int n;
        n = 0;
        ready = '0;
        forever begin
            @(posedge clk);
            ready <= ready_en & NUM_PORTS'(1 << (n % NUM_PORTS));
            n++;
        end
    end

    always @(posedge clk) begin : monitor
        logic [DATA_W+1:0] e;
        if (rst_n) begin
            assert ($countones(~pause) <= 1) else report_problem("more than one pause bit low");
            assert (!full) else report_mismatch("full", 32'(full), 32'd0);
            if (almost_full) begin
                af_cycles++;
                if (in_pkt == '0) begin
                    assert (pause == '1) else
                        report_mismatch("pause", 32'(pause), 32'({NUM_PORTS{1'b1}}));
                end
            end
            // ingress side feeds the reference queues
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (in_pkt[i] && wr_vld[i]) begin
                    assert (!pause[i]) else report_problem("pause rose inside a packet");
                end
                if (wr_vld[i] && !pause[i]) begin
                    if (wr_sop[i] && !in_pkt[i]) begin
                        cur_dest[i] = wr_data[i][DEST_LSB +: DEST_W];
                        in_pkt[i]   = 1'b1;
                    end
                    if (in_pkt[i]) begin
                        exp_q[cur_dest[i]].push_back({wr_sop[i], wr_eop[i], wr_data[i]});
                        if (wr_eop[i]) begin
                            done_q[cur_dest[i]].push_back(cyc);
                            in_pkt[i] = 1'b0;
                        end
                    end
                end
            end
            // egress side
            for (int j = 0; j < NUM_PORTS; j++) begin
                assert (rd_s[j] == exp_s[j]) else
                    report_mismatch($sformatf("rd_s[%0d]", j), 32'(rd_s[j]), 32'(exp_s[j]));
                if (s_prev[j]) begin
                    assert (rd_sop[j] && rd_vld[j]) else
                        report_mismatch($sformatf("rd_sop[%0d]", j), 32'(rd_sop[j]), 32'd1);
                end
                if (body[j]) begin
                    assert (rd_vld[j]) else report_problem("gap in rd_vld inside a packet");
                end
                if (rd_vld[j]) begin
                    if (exp_q[j].size() == 0) begin
                        report_problem($sformatf("output %0d sent a word nobody sent", j));
                    end else begin
                        e = exp_q[j].pop_front();
                        assert (rd_data[j] == e[DATA_W-1:0]) else
                            report_mismatch($sformatf("rd_data[%0d]", j), 32'(rd_data[j]),
                                            32'(e[DATA_W-1:0]));
                        assert (rd_sop[j] == e[DATA_W+1]) else
                            report_mismatch($sformatf("rd_sop[%0d]", j), 32'(rd_sop[j]),
                                            32'(e[DATA_W+1]));
                        assert (rd_eop[j] == e[DATA_W]) else
                            report_mismatch($sformatf("rd_eop[%0d]", j), 32'(rd_eop[j]),
                                            32'(e[DATA_W]));
                    end
                end
                if (rd_s[j] && done_q[j].size() != 0) begin
                    void'(done_q[j].pop_front());
                end
                body[j] = rd_vld[j] && !rd_eop[j];
                // complete packet visible two edges after its eop was taken
                exp_s[j] = ready[j] && !rd_s[j] && !rd_vld[j] && (done_q[j].size() != 0)
                           && (cyc - done_q[j][0] >= 2);
                s_prev[j] = rd_s[j];
            end
            cyc++;
        end
    end

    initial begin : main
        int start_err;
        int src;
        int k;
        int base;
        rst_n    = 1'b0;
        wr_sop   = '0;
        wr_eop   = '0;
        wr_vld   = '0;
        wr_data  = '0;
        ready_en = '0;
        rnd      = 32'd3;

        start_err = err_cnt;
        repeat (3) begin
            @(posedge clk);
            check_idle_outputs();
        end
        rst_n <= 1'b1;
        @(posedge clk);
        check_idle_outputs();
        end_test("reset", start_err);

        start_err = err_cnt;
        ready_en <= '1;
        for (int p = 0; p < 40; p++) begin
            src = int'(next_rand() % 32'(NUM_PORTS));
            send_packet(src, int'(next_rand() % 32'(NUM_PORTS)),
                        1 + int'(next_rand() % 32'd16));
        end
        wait_drained(3000);
        end_test("random traffic", start_err);

        // pulses with nothing queued must be ignored
        start_err = err_cnt;
        repeat (30) @(posedge clk);
        end_test("ready on empty ports", start_err);

        // port 0 withheld until its queue backs up
        start_err = err_cnt;
        ready_en <= ~NUM_PORTS'(1);
        base = af_cycles;
        k = 0;
        while (af_cycles == base && k < 8) begin
            send_packet(int'(next_rand() % 32'(NUM_PORTS)), 0, 16);
            k++;
        end
        if (af_cycles == base) begin
            report_problem("almost_full never rose");
        end
        repeat (20) @(posedge clk);
        assert (pause == '1) else report_mismatch("pause", 32'(pause), 32'({NUM_PORTS{1'b1}}));
        ready_en <= '1;
        wait_drained(3000);
        send_packet(int'(next_rand() % 32'(NUM_PORTS)), 0, 4);
        wait_drained(500);
        end_test("back-pressure", start_err);

        $display("tests 4, errors %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
